// File: all.f
common/iqcor_pkg.sv
iqcor/iq_mul.sv
iqcor/iq_corrector.sv
design/iqcor_regs.sv
design/iqcor_top.sv
bench/tb_iqcor.sv

// File: run.sh
#!/bin/sh
# builds the iq correction bench with verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_iqcor -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_iqcor)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1

// File: bench/tb_iqcor.sv
// directed bench for iqcor_top; assumes zero wait state apb and a consumer taking every beat
`default_nettype none
`timescale 1ns/10ps

module tb_iqcor
  import iqcor_pkg::*;
();

  // ****************************************
  // test lengths and watchdog budget
  // ****************************************

  // stream latency from the timing rules
  localparam int lat_cycles = 5;
  localparam int n_bypass = 64;
  localparam int n_sets = 6;
  localparam int n_per_set = 40;
  localparam int n_gap = 80;
  localparam int n_full = 64;
  localparam int n_rst = 16;
  localparam int n_after = 16;
  // upper bound on apb transfers over all tests
  localparam int n_apb = 64;
  // bubbles can double the gap test
  localparam int n_samples = n_bypass + n_sets * n_per_set + 2 * n_gap + n_full + n_rst + n_after;
  localparam int wd_ns = (n_samples + n_apb) * 8 * 4 + 2000;

  // expected output with its cycle
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
    logic [31:0] cyc;
  } expect_t;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pslverr;
  iq_stream_t  s_in;
  iq_stream_t  s_out;

  expect_t     exp_q[$];
  int          cyc;
  int          errors;
  int          checks;
  integer      seed;

  // bench copy of the configuration
  logic               m_enable;
  logic signed [15:0] m_coef_ii;
  logic signed [15:0] m_coef_qi;
  logic signed [15:0] m_coef_qq;

  iqcor_top u_iqcor_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .s_in    (s_in),
    .s_out   (s_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // cycle count, read before the edge update by the drivers
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ****************************************
  // reference model
  // ****************************************

  // q1.14 product, keep bits 29 to 14 and let the top wrap
  function automatic logic [15:0] scale_i(input logic signed [15:0] i);
    logic signed [63:0] acc;
    if (!m_enable) begin
      return i;
    end
    acc = 64'(m_coef_ii) * 64'(i);
    return acc[29:14];
  endfunction

  function automatic logic [15:0] mix_q(input logic signed [15:0] i, input logic signed [15:0] q);
    logic signed [63:0] acc;
    if (!m_enable) begin
      return q;
    end
    acc = 64'(m_coef_qi) * 64'(i) + 64'(m_coef_qq) * 64'(q);
    return acc[29:14];
  endfunction

  // ****************************************
  // drivers
  // ****************************************

  // setup cycle, then access cycle sampled at the falling edge
  task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_transfer(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
  endtask

  // mapped register write, mirrored into the model
  task automatic set_reg(input logic [7:0] addr, input logic [31:0] value);
    logic err;
    apb_write(addr, value, err);
    checks++;
    assert (!err) else begin
      errors++;
      $display("error: APB write to 0x%02h was answered with pslverr", addr);
    end
    case (addr)
      8'h00: m_enable = value[0];
      8'h04: m_coef_ii = value[15:0];
      8'h08: m_coef_qi = value[15:0];
      8'h0C: m_coef_qq = value[15:0];
      default: ;
    endcase
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    checks++;
    assert (!err && data == expected) else begin
      errors++;
      $display("Mismatch at %0t: reg 0x%02h read 0x%08h err %0b, expected 0x%08h",
               $time, addr, data, err, expected);
    end
  endtask

  // one beat, its expected result goes to the queue
  task automatic send_sample(input logic [15:0] i, input logic [15:0] q);
    iq_stream_t beat;
    expect_t    e;
    beat.valid    = 1'b1;
    beat.sample.i = i;
    beat.sample.q = q;
    @(posedge clk);
    s_in <= beat;
    e.i   = scale_i(i);
    e.q   = mix_q(i, q);
    e.cyc = cyc + 1 + lat_cycles;
    exp_q.push_back(e);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    s_in.valid <= 1'b0;
  endtask

  // random samples, gap_pct percent chance of a bubble before each
  task automatic run_stream(input int n, input int gap_pct);
    logic [31:0] r;
    int          roll;
    for (int k = 0; k < n; k++) begin
      r    = $random(seed);
      roll = $unsigned(r) % 100;
      if (roll < gap_pct) begin
        idle_cycle();
      end
      r = $random(seed);
      send_sample(r[15:0], r[31:16]);
    end
    idle_cycle();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 4 * lat_cycles) begin
      @(posedge clk);
      n++;
    end
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("error: %0d expected samples never came out", exp_q.size());
      exp_q.delete();
    end
  endtask

  // ****************************************
  // output monitor
  // ****************************************

  always @(negedge clk) begin : monitor
    expect_t e;
    if (s_out.valid) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("error: output valid at %0t with no sample in flight", $time);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (s_out.sample.i == e.i && s_out.sample.q == e.q) else begin
          errors++;
          $display("Mismatch at %0t: out i=%h q=%h, expected i=%h q=%h",
                   $time, s_out.sample.i, s_out.sample.q, e.i, e.q);
        end
        assert (cyc == e.cyc) else begin
          errors++;
          $display("Mismatch at %0t: output in cycle %0d, expected cycle %0d", $time, cyc, e.cyc);
        end
      end
    end
  end

  // ****************************************
  // directed tests
  // ****************************************

  task automatic test_registers();
    logic        err;
    logic [31:0] data;
    @(negedge clk);
    checks++;
    assert (!s_out.valid && prdata == 32'h0 && !pslverr) else begin
      errors++;
      $display("Mismatch at %0t: outputs not idle after reset", $time);
    end
    check_reg(8'h00, 32'h0000_0000);
    check_reg(8'h04, 32'h0000_4000);
    check_reg(8'h08, 32'h0000_0000);
    check_reg(8'h0C, 32'h0000_4000);
    // upper halves are dropped
    set_reg(8'h00, 32'hFFFF_FFFF);
    set_reg(8'h04, 32'h1234_ABCD);
    set_reg(8'h08, 32'hDEAD_8001);
    set_reg(8'h0C, 32'h0F0F_7FFF);
    check_reg(8'h00, 32'h0000_0001);
    check_reg(8'h04, 32'h0000_ABCD);
    check_reg(8'h08, 32'h0000_8001);
    check_reg(8'h0C, 32'h0000_7FFF);
    // unmapped and misaligned addresses
    // bit 0 clear and a fresh low half, so an aliased write would change some register
    apb_write(8'h10, 32'h0000_5554, err);
    checks++;
    assert (err) else begin
      errors++;
      $display("error: write to unmapped address 0x10 gave no pslverr");
    end
    apb_read(8'h10, data, err);
    checks++;
    assert (err && data == 32'h0) else begin
      errors++;
      $display("Mismatch at %0t: unmapped read gave 0x%08h err %0b", $time, data, err);
    end
    apb_read(8'h02, data, err);
    checks++;
    assert (err && data == 32'h0) else begin
      errors++;
      $display("Mismatch at %0t: misaligned read gave 0x%08h err %0b", $time, data, err);
    end
    check_reg(8'h00, {31'h0, m_enable});
    check_reg(8'h04, {16'h0, m_coef_ii});
    check_reg(8'h08, {16'h0, m_coef_qi});
    check_reg(8'h0C, {16'h0, m_coef_qq});
  endtask

  task automatic test_bypass();
    set_reg(8'h00, 32'h0);
    run_stream(n_bypass, 0);
    wait_drain();
  endtask

  task automatic test_correction();
    logic [31:0] r;
    for (int s = 0; s < n_sets; s++) begin
      if (s == 0) begin
        set_reg(8'h04, 32'h4000);
        set_reg(8'h08, 32'h0000);
        set_reg(8'h0C, 32'h4000);
      end else if (s == 1) begin
        // minus one on i, small cross term on q
        set_reg(8'h04, 32'hC000);
        set_reg(8'h08, 32'h1000);
        set_reg(8'h0C, 32'h3C00);
      end else begin
        r = $random(seed);
        set_reg(8'h04, r);
        r = $random(seed);
        set_reg(8'h08, r);
        r = $random(seed);
        set_reg(8'h0C, r);
      end
      set_reg(8'h00, 32'h1);
      run_stream(n_per_set, 0);
      wait_drain();
    end
  endtask

  task automatic test_valid_gaps();
    set_reg(8'h04, 32'h3A5C);
    set_reg(8'h08, 32'hF9E0);
    set_reg(8'h0C, 32'h4311);
    set_reg(8'h00, 32'h1);
    run_stream(n_gap, 35);
    wait_drain();
  endtask

  task automatic test_full_rate_reset();
    run_stream(n_full, 0);
    wait_drain();
    for (int k = 0; k < n_rst; k++) begin
      send_sample(16'(k * 16'h0111), 16'(16'h8000 - k));
    end
    // reset lands mid cycle while the pipe is full
    #2;
    arst_n <= 1'b0;
    #1;
    checks++;
    assert (!s_out.valid) else begin
      errors++;
      $display("error: output valid still high after asynchronous reset");
    end
    exp_q.delete();
    @(posedge clk);
    s_in <= '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    m_enable  = 1'b0;
    m_coef_ii = 16'h4000;
    m_coef_qi = 16'h0000;
    m_coef_qq = 16'h4000;
    check_reg(8'h00, 32'h0000_0000);
    check_reg(8'h04, 32'h0000_4000);
    check_reg(8'h08, 32'h0000_0000);
    check_reg(8'h0C, 32'h0000_4000);
    run_stream(n_after, 0);
    wait_drain();
  endtask

  // ****************************************
  // sequence, watchdog and summary
  // ****************************************

  initial begin
    seed      = 32'ha7fa;
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    m_enable  = 1'b0;
    m_coef_ii = 16'h4000;
    m_coef_qi = 16'h0000;
    m_coef_qq = 16'h4000;
    arst_n  <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    s_in    <= '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    test_registers();
    test_bypass();
    test_correction();
    test_valid_gaps();
    test_full_rate_reset();
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("error: %0d samples left in the queue at the end", exp_q.size());
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(wd_ns);
    $display("error: watchdog expired after %0d ns, the run stopped making progress", wd_ns);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/iqcor_top.sv
// iq imbalance correction top; no back-pressure, at most one sample per clock, 5 cycle latency
`default_nettype none
`timescale 1ns/10ps

module iqcor_top
  import iqcor_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  // apb configuration port
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [apb_data_w-1:0] pwdata,
  output logic [apb_data_w-1:0] prdata,
  output logic                  pslverr,
  // sample stream
  input  iq_stream_t            s_in,
  output iq_stream_t            s_out
);

  iqcor_cfg_t cfg;

  // ****************************************
  // register file
  // ****************************************

  iqcor_regs u_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .cfg     (cfg)
  );

  // ****************************************
  // channel correctors
  // ****************************************

  // i channel, scale only, also supplies the output valid
  iq_corrector #(
    .scale_only (1'b1)
  ) u_corr_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (s_in.valid),
    .data      (s_in.sample.i),
    .partner   (s_in.sample.q),
    .cfg       (cfg),
    .valid_out (s_out.valid),
    .data_out  (s_out.sample.i)
  );

  // q channel rebuilt from i and q
  // same latency as the i path so its valid is left open
  iq_corrector #(
    .scale_only (1'b0)
  ) u_corr_q (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (s_in.valid),
    .data      (s_in.sample.q),
    .partner   (s_in.sample.i),
    .cfg       (cfg),
    .valid_out (),
    .data_out  (s_out.sample.q)
  );

endmodule

`default_nettype wire

// File: design/iqcor_regs.sv
// apb completer with zero wait states; only the low 16 bits of pwdata are kept, unmapped addresses error
`default_nettype none
`timescale 1ns/10ps

module iqcor_regs
  import iqcor_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [apb_data_w-1:0] pwdata,
  output logic [apb_data_w-1:0] prdata,
  output logic                  pslverr,
  output iqcor_cfg_t            cfg
);

  reg_addr_e           addr;
  // second cycle of a transfer
  logic                access;
  // paddr is one of the mapped registers
  logic                hit;
  logic                wr_en;
  logic                rd_en;
  logic [sample_w-1:0] rd_word;

  // ****************************************
  // address decode
  // ****************************************

  assign addr   = reg_addr_e'(paddr);
  assign access = psel & penable;

  always_comb begin
    hit     = 1'b1;
    rd_word = '0;
    case (addr)
      reg_ctrl: begin
        // enable in bit 0, rest reads zero
        rd_word = {{(sample_w-1){1'b0}}, cfg.enable};
      end
      reg_coef_ii: begin
        rd_word = cfg.coef_ii;
      end
      reg_coef_qi: begin
        rd_word = cfg.coef_qi;
      end
      reg_coef_qq: begin
        rd_word = cfg.coef_qq;
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  // writes to unmapped addresses are dropped
  assign wr_en = access & pwrite & hit;
  assign rd_en = access & ~pwrite & hit;

  // ****************************************
  // config registers
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg <= cfg_rst;
    end else if (wr_en) begin
      case (addr)
        reg_ctrl: begin
          cfg.enable <= pwdata[0];
        end
        reg_coef_ii: begin
          cfg.coef_ii <= pwdata[sample_w-1:0];
        end
        reg_coef_qi: begin
          cfg.coef_qi <= pwdata[sample_w-1:0];
        end
        reg_coef_qq: begin
          cfg.coef_qq <= pwdata[sample_w-1:0];
        end
        default: begin
          cfg <= cfg;
        end
      endcase
    end
  end

  // ****************************************
  // read data and error
  // ****************************************

  // zero extended, zero outside a read access
  assign prdata = rd_en ? {{(apb_data_w-sample_w){1'b0}}, rd_word} : '0;

  // flagged on reads and writes alike
  assign pslverr = access & ~hit;

endmodule

`default_nettype wire

// File: iqcor/iq_corrector.sv
// one channel of iq correction, 5 cycle latency; coefficient changes apply one cycle late, sums wrap
`default_nettype none
`timescale 1ns/10ps

module iq_corrector
  import iqcor_pkg::*;
#(
  // 1 builds the i channel, data * coef_ii only
  parameter bit scale_only = 1'b0
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       valid,
  input  logic signed [sample_w-1:0] data,
  input  logic signed [sample_w-1:0] partner,
  input  iqcor_cfg_t                 cfg,
  output logic                       valid_out,
  output logic signed [sample_w-1:0] data_out
);

  // own coefficient reset value depends on the channel
  localparam logic signed [sample_w-1:0] own_rst = scale_only ? coef_ii_rst : coef_qq_rst;

  // registered configuration
  logic                       enable_r;
  logic signed [sample_w-1:0] coef_own_r;

  // own product and its side data
  logic signed [prod_w-1:0]   p_own;
  logic                       v_own;
  logic signed [sample_w-1:0] d_own;

  // combined products ahead of the sum register
  logic signed [prod_w-1:0]   sum_s;
  logic                       sum_vld_s;

  // sum stage
  logic signed [prod_w-1:0]   sum_r;
  logic                       sum_vld_r;
  logic signed [sample_w-1:0] own_r;

  // ****************************************
  // coefficient registers
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable_r   <= enable_rst;
      coef_own_r <= own_rst;
    end else begin
      enable_r   <= cfg.enable;
      coef_own_r <= scale_only ? cfg.coef_ii : cfg.coef_qq;
    end
  end

  // own channel, carries valid and the raw sample for bypass
  iq_mul #(
    .side_w (sample_w + 1)
  ) u_mul_own (
    .clk      (clk),
    .arst_n   (arst_n),
    .a        ({data[sample_w-1], data}),
    .b        ({coef_own_r[sample_w-1], coef_own_r}),
    .side_in  ({valid, data}),
    .p        (p_own),
    .side_out ({v_own, d_own})
  );

  if (scale_only) begin : g_scale
    // i channel, nothing to add
    assign sum_s     = p_own;
    assign sum_vld_s = v_own;
  end else begin : g_mix
    logic signed [sample_w-1:0] coef_par_r;
    logic signed [prod_w-1:0]   p_par;
    logic                       v_par;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        coef_par_r <= coef_qi_rst;
      end else begin
        coef_par_r <= cfg.coef_qi;
      end
    end

    // partner channel, only the valid flag rides along
    iq_mul #(
      .side_w (1)
    ) u_mul_par (
      .clk      (clk),
      .arst_n   (arst_n),
      .a        ({partner[sample_w-1], partner}),
      .b        ({coef_par_r[sample_w-1], coef_par_r}),
      .side_in  (valid),
      .p        (p_par),
      .side_out (v_par)
    );

    // both pipes run in lockstep
    assign sum_s     = p_own + p_par;
    assign sum_vld_s = v_own & v_par;
  end

  // ****************************************
  // sum and output registers
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_vld_r <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      sum_vld_r <= sum_vld_s;
      valid_out <= sum_vld_r;
    end
  end

  always_ff @(posedge clk) begin
    sum_r <= sum_s;
    own_r <= d_own;
    // drop the q1.14 fraction, upper bits wrap
    if (enable_r) begin
      data_out <= sum_r[coef_frac_w +: sample_w];
    end else begin
      data_out <= own_r;
    end
  end

endmodule

`default_nettype wire

// File: iqcor/iq_mul.sv
// signed 17x17 multiply in 3 cycles; msb of side data is a valid flag and the only bit reset clears
`default_nettype none
`timescale 1ns/10ps

module iq_mul
  import iqcor_pkg::*;
#(
  parameter int side_w = 1
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic signed [mul_w-1:0]  a,
  input  logic signed [mul_w-1:0]  b,
  input  logic [side_w-1:0]        side_in,
  output logic signed [prod_w-1:0] p,
  output logic [side_w-1:0]        side_out
);

  // operand stage
  logic signed [mul_w-1:0]  a_r;
  logic signed [mul_w-1:0]  b_r;
  // product stages
  logic signed [prod_w-1:0] p_r;
  logic signed [prod_w-1:0] p_rr;
  // valid flag delay, same depth as the product pipe
  logic [mul_latency-1:0]   vld_r;

  // ****************************************
  // product pipe
  // ****************************************

  always_ff @(posedge clk) begin
    a_r  <= a;
    b_r  <= b;
    // full precision, both operands already sign extended
    p_r  <= a_r * b_r;
    p_rr <= p_r;
  end

  assign p = p_rr;

  // ****************************************
  // side data delay line
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_r <= '0;
    end else begin
      vld_r <= {vld_r[mul_latency-2:0], side_in[side_w-1]};
    end
  end

  assign side_out[side_w-1] = vld_r[mul_latency-1];

  // payload bits below the flag, only when there are any
  if (side_w > 1) begin : g_side_data
    logic [side_w-2:0] dat_r [mul_latency];

    always_ff @(posedge clk) begin
      dat_r[0] <= side_in[side_w-2:0];
      for (int k = 1; k < mul_latency; k++) begin
        dat_r[k] <= dat_r[k-1];
      end
    end

    assign side_out[side_w-2:0] = dat_r[mul_latency-1];
  end

endmodule

`default_nettype wire

// File: common/iqcor_pkg.sv
// shared widths, register map and stream types; coefficients are signed q1.14 and results wrap
`default_nettype none

package iqcor_pkg;

  // ****************************************
  // widths and latencies
  // ****************************************

  // one sample component
  localparam int sample_w = 16;
  // q1.14 coefficients, 16'h4000 is unity gain
  localparam int coef_frac_w = 14;
  // multiplier operands get one guard bit
  localparam int mul_w = sample_w + 1;
  localparam int prod_w = 2 * mul_w;
  // register inputs, multiply, register product
  localparam int mul_latency = 3;
  // multiplier plus sum register plus output register
  localparam int corr_latency = mul_latency + 2;

  // apb completer widths
  localparam int apb_addr_w = 8;
  localparam int apb_data_w = 32;

  // ****************************************
  // register map
  // ****************************************

  // byte addresses, anything else raises pslverr
  typedef enum logic [apb_addr_w-1:0] {
    reg_ctrl    = 8'h00,
    reg_coef_ii = 8'h04,
    reg_coef_qi = 8'h08,
    reg_coef_qq = 8'h0C
  } reg_addr_e;

  // ****************************************
  // stream and config types
  // ****************************************

  typedef struct packed {
    logic signed [sample_w-1:0] i;
    logic signed [sample_w-1:0] q;
  } iq_sample_t;

  // no ready, the consumer takes every beat
  typedef struct packed {
    logic       valid;
    iq_sample_t sample;
  } iq_stream_t;

  typedef struct packed {
    logic                       enable;
    // i channel scale
    logic signed [sample_w-1:0] coef_ii;
    // weight of i in the q result
    logic signed [sample_w-1:0] coef_qi;
    // weight of q in the q result
    logic signed [sample_w-1:0] coef_qq;
  } iqcor_cfg_t;

  // reset values, correction off with unity gains
  localparam logic enable_rst = 1'b0;
  localparam logic signed [sample_w-1:0] coef_ii_rst = 16'sh4000;
  localparam logic signed [sample_w-1:0] coef_qi_rst = 16'sh0000;
  localparam logic signed [sample_w-1:0] coef_qq_rst = 16'sh4000;

  localparam iqcor_cfg_t cfg_rst = '{
    enable:  enable_rst,
    coef_ii: coef_ii_rst,
    coef_qi: coef_qi_rst,
    coef_qq: coef_qq_rst
  };

endpackage

`default_nettype wire
